// File: common/backoff_consts.svh
//////////////////////////////////////////////////////////////////////
// Backoff engine constants
// Widths, LFSR seeds, feedback taps and contention window limits
//////////////////////////////////////////////////////////////////////
`ifndef BACKOFF_CONSTS_SVH
`define BACKOFF_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Pseudo random generator
//////////////////////////////////////////////////////////////////////
// LFSR length
`define BACKOFF_PRNG_WIDTH 19
// Reset value of bits 9..0
`define BACKOFF_SEED_LOW   10'b1001110100
// Reset value of bits 18..10
`define BACKOFF_SEED_HIGH  9'b101001101
// Feedback taps, new bit 0 is their xor
`define BACKOFF_TAP_A      16
`define BACKOFF_TAP_B      13

//////////////////////////////////////////////////////////////////////
// Slot count and contention window
//////////////////////////////////////////////////////////////////////
// Width of slot counter and window
`define BACKOFF_CNT_WIDTH  10
// Window limits, both 2^k-1
`define BACKOFF_CW_MIN     10'd15
`define BACKOFF_CW_MAX     10'd1023

`endif

// File: common/backoffPkg.sv
//////////////////////////////////////////////////////////////////////
// Backoff engine types
// Slot counter states and contention window update opcodes
//////////////////////////////////////////////////////////////////////
package backoffPkg;

  ////////////////////////////////////////////////////////////////////
  // Slot counter FSM
  ////////////////////////////////////////////////////////////////////
  // Idle until a draw is loaded
  // Counting while slots remain
  typedef enum logic [1:0]
  {
    BO_IDLE  = 2'd0,
    BO_COUNT = 2'd1
  } backoffStateE;

  ////////////////////////////////////////////////////////////////////
  // Contention window update
  ////////////////////////////////////////////////////////////////////
  // Hold on no outcome
  // Reset to minimum on success
  // Grow to 2*cw+1 on failure
  typedef enum logic [1:0]
  {
    CW_HOLD  = 2'd0,
    CW_RESET = 2'd1,
    CW_GROW  = 2'd2
  } cwOpE;

endpackage

// File: hdl/backoffPRNG.sv
//////////////////////////////////////////////////////////////////////
// Backoff pseudo random generator
// 19-bit Fibonacci LFSR with fixed seeds, advanced once per
// completed backoff
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoffPRNG
(
  // Clock and resets
  input  logic                           macCoreClk,
  input  logic                           macCoreClkHardRst_n,
  input  logic                           macCoreClkSoftRst_n,

  // Completion from slot counter
  input  logic                           backoffDone_p,

  // Random value to window controller
  output logic [`BACKOFF_PRNG_WIDTH-1:0] pseudoRandomNumber
);

  //////////////////////////////////////////////////////////////////////
  // LFSR register
  //////////////////////////////////////////////////////////////////////
  logic [`BACKOFF_PRNG_WIDTH-1:0] randomValue;
  // Feedback bit
  logic                           feedback;

  assign feedback = randomValue[`BACKOFF_TAP_A] ^ randomValue[`BACKOFF_TAP_B];

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      // Seed split in two halves
      randomValue[9:0]                      <= `BACKOFF_SEED_LOW;
      randomValue[`BACKOFF_PRNG_WIDTH-1:10] <= `BACKOFF_SEED_HIGH;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      // Soft reset reloads same seed
      randomValue[9:0]                      <= `BACKOFF_SEED_LOW;
      randomValue[`BACKOFF_PRNG_WIDTH-1:10] <= `BACKOFF_SEED_HIGH;
    end
    else if (backoffDone_p)
    begin
      // Shift toward the MSB, feedback enters at bit 0
      randomValue <= {randomValue[`BACKOFF_PRNG_WIDTH-2:0], feedback};
    end
  end

  // Straight from the register
  assign pseudoRandomNumber = randomValue;

endmodule

// File: hdl/backoffCwCtrl.sv
//////////////////////////////////////////////////////////////////////
// Contention window controller
// Tracks the window from transmission outcomes and draws the
// slot count on a backoff start
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoffCwCtrl
  import backoffPkg::*;
(
  // Clock and resets
  input  logic                           macCoreClk,
  input  logic                           macCoreClkHardRst_n,
  input  logic                           macCoreClkSoftRst_n,

  // Requests and outcomes
  input  logic                           backoffStart_p,
  input  logic                           txSuccess_p,
  input  logic                           txFail_p,

  // Random value from generator
  input  logic [`BACKOFF_PRNG_WIDTH-1:0] pseudoRandomNumber,

  // Draw to slot counter
  output logic [`BACKOFF_CNT_WIDTH-1:0]  drawnSlots,
  output logic                           drawValid_p,

  // Current window
  output logic [`BACKOFF_CNT_WIDTH-1:0]  cwCurrent
);

  //////////////////////////////////////////////////////////////////////
  // Window update
  //////////////////////////////////////////////////////////////////////
  cwOpE                          cwOp;
  logic [`BACKOFF_CNT_WIDTH-1:0] cwNext;

  // Outcome pulses to opcode
  // Fail and success never coincide
  always_comb
  begin
    if (txFail_p)
      cwOp = CW_GROW;
    else if (txSuccess_p)
      cwOp = CW_RESET;
    else
      cwOp = CW_HOLD;
  end

  always_comb
  begin
    case (cwOp)
      CW_GROW:
      begin
        // 2*cw+1, stuck at max
        if (cwCurrent == `BACKOFF_CW_MAX)
          cwNext = `BACKOFF_CW_MAX;
        else
          cwNext = {cwCurrent[`BACKOFF_CNT_WIDTH-2:0], 1'b1};
      end
      CW_RESET: cwNext = `BACKOFF_CW_MIN;
      default:  cwNext = cwCurrent;
    endcase
  end

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      cwCurrent <= `BACKOFF_CW_MIN;
    else if (!macCoreClkSoftRst_n)
      cwCurrent <= `BACKOFF_CW_MIN;
    else
      cwCurrent <= cwNext;
  end

  //////////////////////////////////////////////////////////////////////
  // Slot count draw
  //////////////////////////////////////////////////////////////////////
  // Valid strobe, one cycle after the start
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      drawValid_p <= 1'b0;
    else if (!macCoreClkSoftRst_n)
      drawValid_p <= 1'b0;
    else
      drawValid_p <= backoffStart_p;
  end

  // Masked with the window before any same-cycle update
  always_ff @(posedge macCoreClk)
  begin
    if (backoffStart_p)
      drawnSlots <= pseudoRandomNumber[`BACKOFF_CNT_WIDTH-1:0] & cwCurrent;
  end

endmodule

// File: hdl/backoffSlotCnt.sv
//////////////////////////////////////////////////////////////////////
// Backoff slot counter
// Loads the drawn count, decrements on idle slot boundaries,
// freezes while the medium is busy and pulses on completion
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoffSlotCnt
  import backoffPkg::*;
(
  // Clock and resets
  input  logic                          macCoreClk,
  input  logic                          macCoreClkHardRst_n,
  input  logic                          macCoreClkSoftRst_n,

  // Draw from window controller
  input  logic                          drawValid_p,
  input  logic [`BACKOFF_CNT_WIDTH-1:0] drawnSlots,

  // Slot strobe and medium state
  input  logic                          slotPulse_p,
  input  logic                          mediumBusy,

  // Counter status
  output logic [`BACKOFF_CNT_WIDTH-1:0] backoffCount,
  output backoffStateE                  backoffState,
  output logic                          backoffDone_p
);

  //////////////////////////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////////////////////////
  backoffStateE                  stateNext;
  logic [`BACKOFF_CNT_WIDTH-1:0] countNext;
  logic                          doneNext;
  // Slot boundary with idle medium
  logic                          idleSlot;
  // Count already at zero
  logic                          countZero;

  assign idleSlot  = slotPulse_p & ~mediumBusy;
  assign countZero = (backoffCount == {`BACKOFF_CNT_WIDTH{1'b0}});

  //////////////////////////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    // Hold by default
    stateNext = backoffState;
    countNext = backoffCount;
    doneNext  = 1'b0;

    if (drawValid_p)
    begin
      // New draw restarts from any state
      stateNext = BO_COUNT;
      countNext = drawnSlots;
    end
    else
    begin
      case (backoffState)
        BO_IDLE:
        begin
          // Wait for a draw
          stateNext = BO_IDLE;
        end
        BO_COUNT:
        begin
          // Busy slots leave everything frozen
          if (idleSlot)
          begin
            if (countZero)
            begin
              // Last idle slot, done
              stateNext = BO_IDLE;
              doneNext  = 1'b1;
            end
            else
            begin
              countNext = backoffCount - 1'b1;
            end
          end
        end
        default:
        begin
          // Unused encoding recovers to idle
          stateNext = BO_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      backoffState  <= BO_IDLE;
      backoffCount  <= {`BACKOFF_CNT_WIDTH{1'b0}};
      backoffDone_p <= 1'b0;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      // Back to an idle, empty counter
      backoffState  <= BO_IDLE;
      backoffCount  <= {`BACKOFF_CNT_WIDTH{1'b0}};
      backoffDone_p <= 1'b0;
    end
    else
    begin
      backoffState  <= stateNext;
      backoffCount  <= countNext;
      backoffDone_p <= doneNext;
    end
  end

endmodule

// File: hdl/backoffEngine.sv
//////////////////////////////////////////////////////////////////////
// Backoff engine top level
// Random generator feeds the window controller, whose draw is
// counted down by the slot counter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoffEngine
  import backoffPkg::*;
(
  // Clock and resets
  input  logic                          macCoreClk,
  input  logic                          macCoreClkHardRst_n,
  input  logic                          macCoreClkSoftRst_n,

  // Control from MAC
  input  logic                          backoffStart_p,
  input  logic                          txSuccess_p,
  input  logic                          txFail_p,

  // Medium timing
  input  logic                          slotPulse_p,
  input  logic                          mediumBusy,

  // Status
  output logic                          backoffDone_p,
  output logic [`BACKOFF_CNT_WIDTH-1:0] backoffCount,
  output backoffStateE                  backoffState,
  output logic [`BACKOFF_CNT_WIDTH-1:0] cwCurrent,
  output logic                          drawValid_p
);

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////
  // Generator to window controller
  logic [`BACKOFF_PRNG_WIDTH-1:0] pseudoRandomNumber;
  // Window controller to slot counter
  logic [`BACKOFF_CNT_WIDTH-1:0]  drawnSlots;

  // Shifts once per completed backoff
  backoffPRNG backoffPRNG_i
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .backoffDone_p       (backoffDone_p),
    .pseudoRandomNumber  (pseudoRandomNumber)
  );

  // Window tracking and draw
  backoffCwCtrl backoffCwCtrl_i
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .backoffStart_p      (backoffStart_p),
    .txSuccess_p         (txSuccess_p),
    .txFail_p            (txFail_p),
    .pseudoRandomNumber  (pseudoRandomNumber),
    .drawnSlots          (drawnSlots),
    .drawValid_p         (drawValid_p),
    .cwCurrent           (cwCurrent)
  );

  // Countdown
  backoffSlotCnt backoffSlotCnt_i
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .drawValid_p         (drawValid_p),
    .drawnSlots          (drawnSlots),
    .slotPulse_p         (slotPulse_p),
    .mediumBusy          (mediumBusy),
    .backoffCount        (backoffCount),
    .backoffState        (backoffState),
    .backoffDone_p       (backoffDone_p)
  );

endmodule

// File: sim/backoff_properties.sv
//////////////////////////////////////////////////////////////////////
// Backoff engine assertions
// Completion pulse width, busy freeze and window rules, bound into
// the slot counter and the window controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoff_properties
  import backoffPkg::*;
(
  input logic                          macCoreClk,
  input logic                          macCoreClkHardRst_n,
  input logic                          macCoreClkSoftRst_n,
  // Slot counter side
  input logic                          backoffDone_p,
  input logic [`BACKOFF_CNT_WIDTH-1:0] backoffCount,
  input logic                          mediumBusy,
  input logic                          drawValid_p,
  // Window controller side
  input logic [`BACKOFF_CNT_WIDTH-1:0] cwCurrent,
  input logic                          txSuccess_p,
  input logic                          txFail_p
);

  // Failed assertions, read by the testbench at the end
  int   assertFailures = 0;
  cwOpE cwOp;

  // Same outcome decode as the window update
  always_comb
  begin
    if (txFail_p)
      cwOp = CW_GROW;
    else if (txSuccess_p)
      cwOp = CW_RESET;
    else
      cwOp = CW_HOLD;
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////
  // Completion is a single cycle pulse
  doneOneCycle: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    backoffDone_p |=> !backoffDone_p)
  else
  begin
    $error("backoffDone_p high for more than one cycle");
    assertFailures++;
  end

  // Busy medium freezes the count unless a new draw loads
  busyFreeze: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (mediumBusy && !drawValid_p && macCoreClkSoftRst_n) |=> $stable(backoffCount))
  else
  begin
    $error("backoffCount changed while mediumBusy was high");
    assertFailures++;
  end

  // Window within its limits and always of the form 2^k-1
  cwBounded: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (cwCurrent >= `BACKOFF_CW_MIN) && (cwCurrent <= `BACKOFF_CW_MAX) &&
    ((cwCurrent & (cwCurrent + 1'b1)) == '0))
  else
  begin
    $error("cwCurrent outside the window limits or not of the form 2^k-1");
    assertFailures++;
  end

  // Outcomes are exclusive
  outcomeExclusive: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    !(txSuccess_p && txFail_p))
  else
  begin
    $error("txSuccess_p and txFail_p high together");
    assertFailures++;
  end

  // Success brings the window back to minimum
  cwResetMin: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (cwOp == CW_RESET) |=> (cwCurrent == `BACKOFF_CW_MIN))
  else
  begin
    $error("cwCurrent not at minimum after txSuccess_p");
    assertFailures++;
  end

endmodule

// Counter instance, window ports tied inactive
bind backoffSlotCnt backoff_properties slotCntProps
(
  .macCoreClk          (macCoreClk),
  .macCoreClkHardRst_n (macCoreClkHardRst_n),
  .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
  .backoffDone_p       (backoffDone_p),
  .backoffCount        (backoffCount),
  .mediumBusy          (mediumBusy),
  .drawValid_p         (drawValid_p),
  .cwCurrent           (`BACKOFF_CW_MIN),
  .txSuccess_p         (1'b0),
  .txFail_p            (1'b0)
);

// Window instance, counter ports tied inactive
bind backoffCwCtrl backoff_properties cwCtrlProps
(
  .macCoreClk          (macCoreClk),
  .macCoreClkHardRst_n (macCoreClkHardRst_n),
  .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
  .backoffDone_p       (1'b0),
  .backoffCount        ({`BACKOFF_CNT_WIDTH{1'b0}}),
  .mediumBusy          (1'b0),
  .drawValid_p         (1'b0),
  .cwCurrent           (cwCurrent),
  .txSuccess_p         (txSuccess_p),
  .txFail_p            (txFail_p)
);

// File: sim/backoffEngineTb.sv
//////////////////////////////////////////////////////////////////////
// Backoff engine testbench
// Pattern file stimulus checked against a reference LFSR and
// window model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "backoff_consts.svh"

module backoffEngineTb
  import backoffPkg::*;
();

  // Pattern commands
  localparam logic [3:0] CMD_START   = 4'h1;
  localparam logic [3:0] CMD_SUCCESS = 4'h2;
  localparam logic [3:0] CMD_FAIL    = 4'h3;
  localparam logic [3:0] CMD_SOFTRST = 4'h4;
  localparam logic [3:0] CMD_SLOTS   = 4'h5;
  localparam logic [3:0] CMD_END     = 4'hF;
  localparam int         PATTERN_DEPTH = 64;
  localparam int         WAIT_LIMIT    = 64;

  logic                           macCoreClk;
  logic                           macCoreClkHardRst_n;
  logic                           macCoreClkSoftRst_n;
  logic                           backoffStart_p;
  logic                           txSuccess_p;
  logic                           txFail_p;
  logic                           slotPulse_p;
  logic                           mediumBusy;
  logic                           backoffDone_p;
  logic [`BACKOFF_CNT_WIDTH-1:0]  backoffCount;
  backoffStateE                   backoffState;
  logic [`BACKOFF_CNT_WIDTH-1:0]  cwCurrent;
  logic                           drawValid_p;

  logic [31:0]                    patternMem [0:PATTERN_DEPTH-1];
  integer                         seed;
  // Reference generator, window and count
  logic [`BACKOFF_PRNG_WIDTH-1:0] modelLfsr;
  logic [`BACKOFF_CNT_WIDTH-1:0]  modelCw;
  logic [`BACKOFF_CNT_WIDTH-1:0]  modelCount;

  backoffEngine backoffEngine_i
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .backoffStart_p      (backoffStart_p),
    .txSuccess_p         (txSuccess_p),
    .txFail_p            (txFail_p),
    .slotPulse_p         (slotPulse_p),
    .mediumBusy          (mediumBusy),
    .backoffDone_p       (backoffDone_p),
    .backoffCount        (backoffCount),
    .backoffState        (backoffState),
    .cwCurrent           (cwCurrent),
    .drawValid_p         (drawValid_p)
  );

  // 8 ns clock
  initial
  begin
    macCoreClk = 1'b0;
    forever #4 macCoreClk = ~macCoreClk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic abortRun(input string reason);
    begin
      $display("ERROR at %0t: %s", $time, reason);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
    end
  endtask

  task automatic compareCount(input string sigName,
                              input logic [`BACKOFF_CNT_WIDTH-1:0] expected,
                              input logic [`BACKOFF_CNT_WIDTH-1:0] actual);
    begin
      if (actual !== expected)
      begin
        $display("MISMATCH time=%0t %s expected=%0d actual=%0d",
                 $time, sigName, expected, actual);
        abortRun("count or window value differs");
      end
    end
  endtask

  task automatic compareState(input string sigName, input backoffStateE expected,
                              input backoffStateE actual);
    begin
      if (actual !== expected)
      begin
        $display("MISMATCH time=%0t %s expected=%s(%0d) actual=%s(%0d)",
                 $time, sigName, expected.name(), expected, actual.name(), actual);
        abortRun("slot counter state differs");
      end
    end
  endtask

  task automatic waitDrawValid();
    int waitCycles;
    begin
      waitCycles = 0;
      while (!drawValid_p && waitCycles < WAIT_LIMIT)
      begin
        @(negedge macCoreClk);
        waitCycles++;
      end
      if (!drawValid_p)
        abortRun("drawValid_p pulse never arrived");
    end
  endtask

  task automatic waitDone();
    int waitCycles;
    begin
      waitCycles = 0;
      while (!backoffDone_p && waitCycles < WAIT_LIMIT)
      begin
        @(negedge macCoreClk);
        waitCycles++;
      end
      if (!backoffDone_p)
        abortRun("backoffDone_p pulse never arrived");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////////////////////////
  task automatic doStart(input logic [`BACKOFF_CNT_WIDTH-1:0] expCw,
                         input logic [`BACKOFF_CNT_WIDTH-1:0] expDraw);
    logic [`BACKOFF_CNT_WIDTH-1:0] modelDraw;
    begin
      // Pattern values against the reference
      modelDraw = modelLfsr[`BACKOFF_CNT_WIDTH-1:0] & modelCw;
      compareCount("modelCw", expCw, modelCw);
      compareCount("modelDraw", expDraw, modelDraw);
      compareCount("cwCurrent", expCw, cwCurrent);
      backoffStart_p = 1'b1;
      @(negedge macCoreClk);
      backoffStart_p = 1'b0;
      waitDrawValid();
      // Counter loads on the second edge
      @(negedge macCoreClk);
      compareCount("backoffCount", expDraw, backoffCount);
      compareState("backoffState", BO_COUNT, backoffState);
      if (drawValid_p)
        abortRun("drawValid_p stayed high for more than one cycle");
      modelCount = expDraw;
    end
  endtask

  task automatic doOutcome(input logic isFail, input logic [`BACKOFF_CNT_WIDTH-1:0] expCw);
    int growCw;
    begin
      // Twice plus one, capped at the maximum
      growCw = 2 * modelCw + 1;
      if (!isFail)
        modelCw = `BACKOFF_CW_MIN;
      else if (growCw > `BACKOFF_CW_MAX)
        modelCw = `BACKOFF_CW_MAX;
      else
        modelCw = growCw[`BACKOFF_CNT_WIDTH-1:0];
      compareCount("modelCw", expCw, modelCw);
      txFail_p    = isFail;
      txSuccess_p = !isFail;
      @(negedge macCoreClk);
      txFail_p    = 1'b0;
      txSuccess_p = 1'b0;
      compareCount("cwCurrent", expCw, cwCurrent);
    end
  endtask

  task automatic doSoftReset(input logic [`BACKOFF_CNT_WIDTH-1:0] expCw);
    begin
      macCoreClkSoftRst_n = 1'b0;
      @(negedge macCoreClk);
      macCoreClkSoftRst_n = 1'b1;
      modelLfsr  = {`BACKOFF_SEED_HIGH, `BACKOFF_SEED_LOW};
      modelCw    = `BACKOFF_CW_MIN;
      modelCount = '0;
      compareCount("cwCurrent", expCw, cwCurrent);
      compareCount("backoffCount", modelCount, backoffCount);
      compareState("backoffState", BO_IDLE, backoffState);
    end
  endtask

  // Busy pulses hold the count, completion on the last pulse only
  task automatic runSlots(input int total, input logic [15:0] busyMask);
    int   pulseIdx;
    int   gap;
    logic busy;
    begin
      for (pulseIdx = 0; pulseIdx < total; pulseIdx++)
      begin
        busy = (pulseIdx < 16) ? busyMask[pulseIdx] : 1'b0;
        gap  = $random(seed) & 3;
        mediumBusy = busy;
        repeat (gap) @(negedge macCoreClk);
        slotPulse_p = 1'b1;
        @(negedge macCoreClk);
        slotPulse_p = 1'b0;
        mediumBusy  = 1'b0;
        if (pulseIdx < total - 1)
        begin
          if (backoffDone_p)
            abortRun("backoffDone_p pulsed before the last slot pulse of the run");
          if (!busy)
          begin
            if (modelCount == 0)
              abortRun("pattern slot run is longer than the drawn count allows");
            modelCount = modelCount - 1'b1;
          end
          compareCount("backoffCount", modelCount, backoffCount);
        end
        else
        begin
          if (busy || modelCount != 0)
            abortRun("pattern slot run ends before the drawn count reaches zero");
          waitDone();
          compareState("backoffState", BO_IDLE, backoffState);
        end
      end
      // Generator shifts on the done edge
      @(negedge macCoreClk);
      if (backoffDone_p)
        abortRun("backoffDone_p held for more than one cycle");
      modelLfsr = {modelLfsr[`BACKOFF_PRNG_WIDTH-2:0],
                   modelLfsr[`BACKOFF_TAP_A] ^ modelLfsr[`BACKOFF_TAP_B]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    int          patternIdx;
    int          assertFailures;
    logic        running;
    logic [31:0] entry;
    macCoreClkHardRst_n = 1'b0;
    macCoreClkSoftRst_n = 1'b1;
    backoffStart_p      = 1'b0;
    txSuccess_p         = 1'b0;
    txFail_p            = 1'b0;
    slotPulse_p         = 1'b0;
    mediumBusy          = 1'b0;
    seed                = 67;
    modelLfsr           = {`BACKOFF_SEED_HIGH, `BACKOFF_SEED_LOW};
    modelCw             = `BACKOFF_CW_MIN;
    modelCount          = '0;
    $readmemh("sim/backoff_patterns.txt", patternMem);

    // Hard reset for 8 cycles
    repeat (8) @(negedge macCoreClk);
    macCoreClkHardRst_n = 1'b1;
    @(negedge macCoreClk);
    compareCount("cwCurrent", `BACKOFF_CW_MIN, cwCurrent);
    compareCount("backoffCount", '0, backoffCount);
    compareState("backoffState", BO_IDLE, backoffState);
    if (backoffDone_p || drawValid_p)
      abortRun("a pulse output is high after reset");

    patternIdx = 0;
    running    = 1'b1;
    while (running)
    begin
      if (patternIdx >= PATTERN_DEPTH)
        abortRun("pattern file has no end command");
      entry = patternMem[patternIdx];
      if ($isunknown(entry))
        abortRun("pattern entry is missing or unreadable");
      case (entry[31:28])
        CMD_START:   doStart(entry[25:16], entry[9:0]);
        CMD_SUCCESS: doOutcome(1'b0, entry[25:16]);
        CMD_FAIL:    doOutcome(1'b1, entry[25:16]);
        CMD_SOFTRST: doSoftReset(entry[25:16]);
        CMD_SLOTS:   runSlots(int'(entry[27:16]), entry[15:0]);
        CMD_END:     running = 1'b0;
        default:     abortRun("unknown command in pattern file");
      endcase
      patternIdx++;
    end

    // Let the last properties evaluate
    repeat (2) @(negedge macCoreClk);
    assertFailures = backoffEngine_i.backoffSlotCnt_i.slotCntProps.assertFailures +
                     backoffEngine_i.backoffCwCtrl_i.cwCtrlProps.assertFailures;
    if (assertFailures == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERROR: %0d assertion failures", assertFailures);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
    end
  end

endmodule

// File: src.f
+incdir+common
common/backoffPkg.sv
hdl/backoffPRNG.sv
hdl/backoffCwCtrl.sv
hdl/backoffSlotCnt.sv
hdl/backoffEngine.sv
sim/backoff_properties.sv
sim/backoffEngineTb.sv

// File: sim/backoff_patterns.txt
// Word layout: cmd[31:28] fieldA[27:16] fieldB[15:0], one hex word per line
// cmd 1 start (A window, B draw), 2 success (A window), 3 fail (A window)
// cmd 4 soft reset (A window), 5 slot run (A pulses, B busy mask, bit 0 first)
// cmd F end of patterns
100F0004 // first draw after hard reset
5007000A // pulses 1 and 3 busy
301F0000 // fail, window 31
101F0008 // draw from shifted value
101F0008 // restart, same value
500A0001 // first pulse busy
303F0000 // fail, 63
307F0000 // fail, 127
30FF0000 // fail, 255
31FF0000 // fail, 511
33FF0000 // fail, 1023
33FF0000 // saturated
13FF01D1 // full width mask
200F0000 // success, back to 15
100F0001 // restart with small window
50030001 // busy first pulse
100F0002 // third shift
301F0000 // grow before soft reset
400F0000 // soft reset
100F0004 // matches first draw
50050000 // all idle
F0000000
